// File: common/fetch_pkg.sv
/*
 * Fetch side definitions
 * Address and instruction widths, the reset PC and the PC step
 * shared by the PC generator, the cache interface and the top level
 */
package fetch_pkg;

    // Virtual address width of a fetch
    localparam int ADDR_SIZE = 40;

    // One PC or fetch address
    typedef logic [ADDR_SIZE-1:0] addr_t;

    // Width of one instruction word
    localparam int INSTR_SIZE = 32;

    // One instruction word
    typedef logic [INSTR_SIZE-1:0] instr_t;

    // First address fetched after reset
    localparam addr_t RESET_PC = '0;

    // Byte distance between two sequential instructions
    localparam addr_t PC_STEP = addr_t'(INSTR_SIZE / 8);

endpackage

// File: common/icache_pkg.sv
/*
 * Instruction cache definitions
 * Line geometry, line memory depth, response latency and the
 * states of the cache interface FSM
 */
package icache_pkg;

    // One cache line holds four instructions
    localparam int LINE_SIZE      = 128;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BYTES     = LINE_SIZE / 8;

    // Address bits inside a line and bits that pick a word
    localparam int LINE_OFFSET   = $clog2(LINE_BYTES);
    localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);

    typedef logic [LINE_SIZE-1:0] icache_line_t;

    // Populated lines of the backing memory
    localparam int MEM_LINES     = 64;
    localparam int LINE_IDX_BITS = $clog2(MEM_LINES);

    typedef logic [LINE_IDX_BITS-1:0] line_idx_t;

    // Cycles from request pulse to response valid
    localparam int ICACHE_LATENCY = 2;

    // Interface FSM
    typedef enum logic [1:0] {
        ResetState,
        NoReq,
        ReqValid
    } icache_state_t;

endpackage

// File: logic/fetch_pc_gen.sv
/*
 * Fetch PC generator
 * Holds the fetch PC, steps it one word per accepted instruction
 * and loads a redirect target, which wins over stepping
 */
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic             clk_i,
    input  logic             rstn_i,

    // Branch style redirect
    input  logic             redirect_valid_i,
    input  fetch_pkg::addr_t redirect_pc_i,

    // Handshake of the instruction leaving the front end
    input  logic             instr_valid_i,
    input  logic             instr_ready_i,

    // Fetch request towards the cache interface
    output logic             req_valid_o,
    output fetch_pkg::addr_t req_pc_o
);

    import fetch_pkg::*;

    logic  req_valid_q;
    addr_t req_pc_q;
    logic  accept;

    // Instruction taken by decode this cycle
    assign accept = instr_valid_i & instr_ready_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            req_valid_q <= 1'b0;
            req_pc_q    <= RESET_PC;
        end else begin
            // Requests run continuously once out of reset
            req_valid_q <= 1'b1;
            if (redirect_valid_i) begin
                // Low two bits are ignored
                req_pc_q <= {redirect_pc_i[ADDR_SIZE-1:2], 2'b00};
            end else if (accept) begin
                req_pc_q <= req_pc_q + PC_STEP;
            end
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_pc_o    = req_pc_q;

    // Every PC presented for fetch stays on a word boundary
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_o |-> (req_pc_o[1:0] == 2'b00));

endmodule

// File: icache/icache_interface.sv
/*
 * Instruction cache interface
 * Keeps one line buffer with its tag, decides between a buffer hit
 * and a line request, and hands one 32-bit word per cycle to decode.
 * The tag is captured when the request leaves, so a late response
 * is filed under the address that was actually asked for.
 */
`timescale 1ns/1ps

module icache_interface (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    // Request from the PC generator
    input  logic                    req_valid_i,
    input  fetch_pkg::addr_t        req_pc_i,

    // Line request to the instruction cache
    output logic                    icache_req_valid_o,
    output fetch_pkg::addr_t        icache_req_addr_o,

    // Line response, always accepted
    input  logic                    icache_resp_valid_i,
    input  icache_pkg::icache_line_t icache_resp_line_i,
    input  logic                    icache_resp_fault_i,

    // Instruction towards decode
    output logic                    instr_valid_o,
    output fetch_pkg::instr_t       instr_o,
    output fetch_pkg::addr_t        instr_pc_o,
    output logic                    instr_fault_o
);

    import fetch_pkg::*;
    import icache_pkg::*;

    icache_state_t state_q, state_d;

    // Line buffer
    logic                             buf_valid_q;
    logic [ADDR_SIZE-1:LINE_OFFSET]   buf_tag_q;
    icache_line_t                     buf_line_q;

    // Tag of the outstanding request
    logic [ADDR_SIZE-1:LINE_OFFSET]   req_tag_q;

    logic [ADDR_SIZE-1:LINE_OFFSET]   pc_tag;
    logic [WORD_SEL_BITS-1:0]         word_sel;
    logic                             buf_hit;
    logic                             resp_match;
    logic                             miss_req;
    icache_line_t                     sel_line;
    instr_t                           sel_word;

    assign pc_tag   = req_pc_i[ADDR_SIZE-1:LINE_OFFSET];
    assign word_sel = req_pc_i[LINE_OFFSET-1 -: WORD_SEL_BITS];

    // Hit on the buffered line
    assign buf_hit = buf_valid_q & (buf_tag_q == pc_tag);

    // Response belongs to the PC being fetched right now
    assign resp_match = (state_q == ReqValid) & icache_resp_valid_i & (req_tag_q == pc_tag);

    // New line needed, only issued from NoReq
    assign miss_req = (state_q == NoReq) & req_valid_i & ~buf_hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ResetState: state_d = NoReq;
            NoReq: begin
                if (miss_req) begin
                    state_d = ReqValid;
                end
            end
            ReqValid: begin
                // Back to NoReq whether or not the line is still wanted
                if (icache_resp_valid_i) begin
                    state_d = NoReq;
                end
            end
            default: state_d = ResetState;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= ResetState;
            buf_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // A faulting line never enters the buffer
            if (icache_resp_valid_i && !icache_resp_fault_i) begin
                buf_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss_req) begin
            req_tag_q <= pc_tag;
        end
        if (icache_resp_valid_i && !icache_resp_fault_i) begin
            buf_tag_q  <= req_tag_q;
            buf_line_q <= icache_resp_line_i;
        end
    end

    // Line request, aligned to the line
    assign icache_req_valid_o = miss_req;
    assign icache_req_addr_o  = {pc_tag, {LINE_OFFSET{1'b0}}};

    // Word straight from the response, else from the buffer
    assign sel_line = resp_match ? icache_resp_line_i : buf_line_q;
    assign sel_word = sel_line[word_sel*INSTR_SIZE +: INSTR_SIZE];

    assign instr_valid_o = req_valid_i & (state_q != ResetState) & (buf_hit | resp_match);
    assign instr_fault_o = resp_match & icache_resp_fault_i;
    assign instr_o       = instr_fault_o ? '0 : sel_word;
    assign instr_pc_o    = req_pc_i;

    // One request in flight at a time, no new request while a line is outstanding
    a_no_req_in_flight: assert property (@(posedge clk_i) disable iff (!rstn_i)
        icache_req_valid_o |->
            (!$past(icache_req_valid_o, 1) && !$past(icache_req_valid_o, ICACHE_LATENCY)));

    // Memory answers only to an issued request
    a_no_stray_resp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q == NoReq) |-> !icache_resp_valid_i);

endmodule

// File: icache/icache_line_mem.sv
/*
 * Instruction line memory
 * Stands in for the instruction cache. Lines are preloaded through
 * a load port and returned whole after a fixed latency. Addresses
 * past the populated lines answer with an access fault.
 */
`timescale 1ns/1ps

module icache_line_mem (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    // Preload port
    input  logic                     load_valid_i,
    input  icache_pkg::line_idx_t    load_idx_i,
    input  icache_pkg::icache_line_t load_line_i,

    // Line request
    input  logic                     req_valid_i,
    input  fetch_pkg::addr_t         req_addr_i,

    // Line response after the fixed latency
    output logic                     resp_valid_o,
    output icache_pkg::icache_line_t resp_line_o,
    output logic                     resp_fault_o
);

    import fetch_pkg::*;
    import icache_pkg::*;

    icache_line_t mem_q [MEM_LINES];

    // Delay line, one entry per cycle of latency
    logic         pipe_valid_q [ICACHE_LATENCY];
    addr_t        pipe_addr_q  [ICACHE_LATENCY];
    icache_line_t pipe_line_q  [ICACHE_LATENCY];

    line_idx_t    req_idx;
    icache_line_t req_line;

    // Line number at or past the populated range
    function automatic logic out_of_range(addr_t addr);
        return addr[ADDR_SIZE-1:LINE_OFFSET] >= (ADDR_SIZE-LINE_OFFSET)'(MEM_LINES);
    endfunction

    always_ff @(posedge clk_i) begin
        if (load_valid_i) begin
            mem_q[load_idx_i] <= load_line_i;
        end
    end

    // Lookup at request time, zero line when out of range
    assign req_idx  = req_addr_i[LINE_OFFSET +: LINE_IDX_BITS];
    assign req_line = out_of_range(req_addr_i) ? '0 : mem_q[req_idx];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < ICACHE_LATENCY; i++) begin
                pipe_valid_q[i] <= 1'b0;
            end
        end else begin
            pipe_valid_q[0] <= req_valid_i;
            for (int i = 1; i < ICACHE_LATENCY; i++) begin
                pipe_valid_q[i] <= pipe_valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        pipe_addr_q[0] <= req_addr_i;
        pipe_line_q[0] <= req_line;
        for (int i = 1; i < ICACHE_LATENCY; i++) begin
            pipe_addr_q[i] <= pipe_addr_q[i-1];
            pipe_line_q[i] <= pipe_line_q[i-1];
        end
    end

    assign resp_valid_o = pipe_valid_q[ICACHE_LATENCY-1];
    assign resp_line_o  = pipe_line_q[ICACHE_LATENCY-1];
    assign resp_fault_o = resp_valid_o & out_of_range(pipe_addr_q[ICACHE_LATENCY-1]);

    // Preload and fetch never overlap
    a_load_vs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(load_valid_i && req_valid_i));

endmodule

// File: logic/fetch_top.sv
/*
 * Instruction fetch front end
 * PC generator feeding the cache interface, which is backed by
 * the preloadable line memory
 */
`timescale 1ns/1ps

module fetch_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    // Line memory preload
    input  logic                     load_valid_i,
    input  icache_pkg::line_idx_t    load_idx_i,
    input  icache_pkg::icache_line_t load_line_i,

    // Branch redirect
    input  logic                     redirect_valid_i,
    input  fetch_pkg::addr_t         redirect_pc_i,

    // Decode side
    input  logic                     instr_ready_i,
    output logic                     instr_valid_o,
    output fetch_pkg::instr_t        instr_o,
    output fetch_pkg::addr_t         instr_pc_o,
    output logic                     instr_fault_o
);

    import fetch_pkg::*;
    import icache_pkg::*;

    // Generator to interface
    logic         req_valid;
    addr_t        req_pc;

    // Interface to line memory
    logic         icache_req_valid;
    addr_t        icache_req_addr;
    logic         icache_resp_valid;
    icache_line_t icache_resp_line;
    logic         icache_resp_fault;

    fetch_pc_gen fetch_pc_gen_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .instr_valid_i    (instr_valid_o),
        .instr_ready_i    (instr_ready_i),
        .req_valid_o      (req_valid),
        .req_pc_o         (req_pc)
    );

    icache_interface icache_interface_i (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .req_valid_i         (req_valid),
        .req_pc_i            (req_pc),
        .icache_req_valid_o  (icache_req_valid),
        .icache_req_addr_o   (icache_req_addr),
        .icache_resp_valid_i (icache_resp_valid),
        .icache_resp_line_i  (icache_resp_line),
        .icache_resp_fault_i (icache_resp_fault),
        .instr_valid_o       (instr_valid_o),
        .instr_o             (instr_o),
        .instr_pc_o          (instr_pc_o),
        .instr_fault_o       (instr_fault_o)
    );

    icache_line_mem icache_line_mem_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .load_valid_i (load_valid_i),
        .load_idx_i   (load_idx_i),
        .load_line_i  (load_line_i),
        .req_valid_i  (icache_req_valid),
        .req_addr_i   (icache_req_addr),
        .resp_valid_o (icache_resp_valid),
        .resp_line_o  (icache_resp_line),
        .resp_fault_o (icache_resp_fault)
    );

endmodule

// File: sim/tb_fetch_ref.svh
/*
 * Fetch testbench reference
 * Copy of the preloaded line memory, the random seed, the expected
 * instruction for a PC and the value compare used by the checker
 */
`ifndef TB_FETCH_REF_SVH
`define TB_FETCH_REF_SVH

// Seed for preload data and decode back-pressure
integer seed = 32'h1eb0;

// Lines as written through the load port
icache_line_t model_mem [MEM_LINES];

// Fault past the populated lines, else word PC[3:2] of the model line
function automatic void expected_fetch(input addr_t pc, output instr_t instr,
                                       output logic fault);
    logic [ADDR_SIZE-5:0] line_no;
    icache_line_t         line;
    line_no = pc[ADDR_SIZE-1:4];
    if (line_no >= (ADDR_SIZE-4)'(MEM_LINES)) begin
        fault = 1'b1;
        instr = '0;
    end else begin
        line  = model_mem[line_idx_t'(line_no)];
        fault = 1'b0;
        instr = line[32*pc[3:2] +: 32];
    end
endfunction

// Compare one observed value with its expected value
task automatic check_value(input string what, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
        $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        $display("Errors found");
        $fatal(1, "Stopped at the first mismatch");
    end
endtask

`endif

// File: sim/tb_fetch_top.sv
/*
 * Fetch front end testbench
 * Preloads the line memory during reset, then runs sequential
 * fetch, random decode stalls, redirects and faulting fetches
 * while a checker compares every accepted instruction
 */
`timescale 1ns/1ps

module tb_fetch_top;

    import fetch_pkg::*;
    import icache_pkg::*;

    `include "tb_fetch_ref.svh"

    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 64;

    logic         clk_i;
    logic         rstn_i;
    logic         load_valid_i;
    line_idx_t    load_idx_i;
    icache_line_t load_line_i;
    logic         redirect_valid_i;
    addr_t        redirect_pc_i;
    logic         instr_ready_i;
    logic         instr_valid_o;
    instr_t       instr_o;
    addr_t        instr_pc_o;
    logic         instr_fault_o;

    // Checker state
    addr_t exp_pc;
    int    accept_count;
    int    cycle_count;
    int    last_accept_cycle;
    logic  seq_check;
    logic  chain_ok;

    fetch_top fetch_top_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .load_valid_i     (load_valid_i),
        .load_idx_i       (load_idx_i),
        .load_line_i      (load_line_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .instr_ready_i    (instr_ready_i),
        .instr_valid_o    (instr_valid_o),
        .instr_o          (instr_o),
        .instr_pc_o       (instr_pc_o),
        .instr_fault_o    (instr_fault_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic timeout_abort(input string what);
        $display("Errors found");
        $fatal(1, "Timeout while waiting for %s", what);
    endtask

    // Accepts and redirects are taken at the rising edge
    always @(posedge clk_i) begin : compare_proc
        instr_t exp_instr;
        logic   exp_fault;
        if (!rstn_i) begin
            check_value("instr_valid_o in reset", 64'(instr_valid_o), 64'd0);
            exp_pc       = RESET_PC;
            accept_count = 0;
            cycle_count  = 0;
            chain_ok     = 1'b0;
        end else begin
            cycle_count = cycle_count + 1;
            if (instr_valid_o && instr_ready_i) begin
                expected_fetch(exp_pc, exp_instr, exp_fault);
                check_value("instr_pc_o", 64'(instr_pc_o), 64'(exp_pc));
                check_value("instr_fault_o", 64'(instr_fault_o), 64'(exp_fault));
                check_value("instr_o", 64'(instr_o), 64'(exp_instr));
                // Words after the first of a line hit in the buffer
                if (seq_check && chain_ok && exp_pc[3:2] != 2'b00) begin
                    check_value("cycles between accepts",
                                64'(cycle_count - last_accept_cycle), 64'd1);
                end
                last_accept_cycle = cycle_count;
                accept_count      = accept_count + 1;
            end
            if (redirect_valid_i) begin
                exp_pc   = {redirect_pc_i[ADDR_SIZE-1:2], 2'b00};
                chain_ok = 1'b0;
            end else if (instr_valid_o && instr_ready_i) begin
                exp_pc   = exp_pc + addr_t'(4);
                chain_ok = 1'b1;
            end
        end
    end

    // Fill every line with random data, one line per cycle
    task automatic preload_memory();
        icache_line_t line;
        for (int i = 0; i < MEM_LINES; i++) begin
            line = {$random(seed), $random(seed), $random(seed), $random(seed)};
            @(negedge clk_i);
            load_valid_i = 1'b1;
            load_idx_i   = line_idx_t'(i);
            load_line_i  = line;
            model_mem[i] = line;
        end
        @(negedge clk_i);
        load_valid_i = 1'b0;
    endtask

    task automatic wait_accepts(input int count, input string what);
        int target;
        int waited;
        target = accept_count + count;
        waited = 0;
        while (accept_count < target) begin
            @(negedge clk_i);
            waited++;
            if (waited > count * 8 + WAIT_LIMIT) timeout_abort(what);
        end
    endtask

    // Random decode stalls until enough instructions went through
    task automatic random_ready_run(input int count);
        int target;
        int waited;
        target = accept_count + count;
        waited = 0;
        while (accept_count < target) begin
            instr_ready_i = 1'($random(seed));
            @(negedge clk_i);
            waited++;
            if (waited > count * 8 + WAIT_LIMIT) timeout_abort("accepts under back-pressure");
        end
        instr_ready_i = 1'b1;
    endtask

    // Called at a falling edge, redirect held for one cycle
    task automatic redirect_to(input addr_t pc);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = pc;
        @(negedge clk_i);
        redirect_valid_i = 1'b0;
    endtask

    // Second redirect lands while the first target's line is in flight
    task automatic redirect_in_miss(input addr_t first_pc, input addr_t second_pc);
        int waited;
        redirect_to(first_pc);
        waited = 0;
        while (!fetch_top_i.icache_req_valid) begin
            @(negedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) timeout_abort("a line request after redirect");
        end
        @(negedge clk_i);
        redirect_to(second_pc);
    endtask

    initial begin : stimulus
        int latency;
        rstn_i           = 1'b0;
        load_valid_i     = 1'b0;
        load_idx_i       = '0;
        load_line_i      = '0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        instr_ready_i    = 1'b0;
        seq_check        = 1'b0;

        // Reset stays low over the preload, then 16 more cycles
        preload_memory();
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i        = 1'b1;
        instr_ready_i = 1'b1;
        seq_check     = 1'b1;

        // First cycle out of reset starts at this edge
        @(posedge clk_i);
        latency = 0;
        while (!instr_valid_o) begin
            @(negedge clk_i);
            latency++;
            if (latency > WAIT_LIMIT) timeout_abort("the first instruction");
        end
        check_value("first fetch latency", 64'(latency - 1), 64'(ICACHE_LATENCY));

        wait_accepts(12, "sequential fetch");
        seq_check = 1'b0;

        random_ready_run(40);

        redirect_to(addr_t'(32'h200));
        wait_accepts(5, "fetch after redirect");

        redirect_in_miss(addr_t'(32'h344), addr_t'(32'h108));
        wait_accepts(6, "fetch after redirect during a miss");

        // Past the populated lines and back
        redirect_to(addr_t'(MEM_LINES * LINE_BYTES + 36));
        wait_accepts(3, "faulting fetch");
        redirect_to(addr_t'(32'h0c0));
        wait_accepts(4, "fetch after fault");

        // Walk off the end of the memory
        redirect_to(addr_t'(MEM_LINES * LINE_BYTES - 8));
        wait_accepts(4, "fetch across the memory end");
        redirect_to(addr_t'(32'h10));
        random_ready_run(12);

        $display("No errors");
        $finish;
    end

endmodule

// File: sources.f
+incdir+sim
common/fetch_pkg.sv
common/icache_pkg.sv
logic/fetch_pc_gen.sv
icache/icache_interface.sv
icache/icache_line_mem.sv
logic/fetch_top.sv
sim/tb_fetch_top.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_fetch_top
FILELIST  := sources.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
